// ==== tb/pat_testdata.txt ====
// one hex word per record, top digit is the kind, 0 instruction (low 20 bits)
// 1 expected result as 1 0 acc(2 digits) z n, 2 end of test
// test 1 immediate ops
000605 000F80 100500                                  // ldi 05
000030 000F80 103500 00011C 000F80 101400             // or 30, and 1c
0004F0 000F80 100400 000509 000F80 10FB00 200000      // add wraps, sub below zero
// test 2 data memory
000707 000F80 100000                                  // word never written reads 0
000612 000B02 000634 000B05 000702 000F80 101200      // stm, stm, ldm
000205 000F80 104600 000302 000F80 103400             // addm, subm
000D02 000F80 103600 000E05 000F80 103400             // orm, andm
000B06 000206 000F80 106800                           // stm then addm back to back
000703 000F80 100000 200000
// test 3 shifts
000696 000F00 000F80 109600 000F01 000F80 102C00      // shl 0, shl 1
000F23 000F80 100500 000F13 000F80 102F00             // shr 3, shlo 3
000696 000F31 000F80 10CB00 000F37 000F80 10FF00      // asr on negative
000F27 000F80 100100 000F17 000F80 10FF00             // shr 7, shlo 7
000F07 000F80 108000 000F10 000F80 108000 200000      // shl 7, shlo 0
// test 4 flags
00065A 000FF0 000FF2 000F80 10A501                    // not then test
0005A5 000F80 100001 000FF2 000F80 100010             // sub to zero
000680 000F80 108010 000FF2 000F80 108001             // negative load
000480 000F80 100001 200000                           // flags stay put
// test 5 nops, field ops and unused codes
001605 000855 000977 000A11 000C22 000F45 000FF1 006FF5 001B02 000F80 100001
000702 000F80 101201 0A6607 000F80 100701 200000      // cond and fieldp bits ignored
// test 6 back-pressure
000601 000F80 100101 000401 000F80 100201 000402 000F80 100401
000404 000F80 100801 000F01 000F80 101001 000B01 000201 000F80 102001
000FF2 000F80 102000 0006FF 000F80 000F80 000F80 10FF00 10FF00 10FF00
0005FF 000F80 100000 200000

// ==== sim.f ====
src/pat_pkg.sv
src/stream_skid.sv
src/instr_decode.sv
src/pat_alu.sv
src/exec_stage.sv
src/pat_core.sv
tb/pat_core_properties.sv
tb/tb_pat_core.sv

// ==== Makefile ====
# verilator build and run of the pat_core testbench

TOP := tb_pat_core

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== tb/tb_pat_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pat_core
	import pat_pkg::*;
();

	// ======================================================================
	// DUT signals and bookkeeping
	// ======================================================================
	logic        clk;
	logic        reset;
	instr_t      i_instr;
	logic        i_instr_valid;
	logic        o_instr_ready;
	result_t     o_out;
	logic        o_out_valid;
	logic        i_out_ready;

	logic [23:0] tdata [256];   // raw records with the kind in the top digit
	logic [19:0] instr_q [$];   // instruction words in program order
	logic [23:0] exp_q [$];     // expected result records
	int          exp_count [$]; // results per test
	int          n_records;
	int          errors;
	int          checks;
	int          received;
	int          extras;
	int          cycles;
	int          limit;         // timeout in cycles that stays 0 until data is loaded
	logic [31:0] gap_rng;       // source gaps
	logic [31:0] ready_rng;     // sink back-pressure

	pat_core UUT (
		.clk           (clk),
		.reset         (reset),
		.i_instr       (i_instr),
		.i_instr_valid (i_instr_valid),
		.o_instr_ready (o_instr_ready),
		.o_out         (o_out),
		.o_out_valid   (o_out_valid),
		.i_out_ready   (i_out_ready)
	);

	bind pat_core pat_core_properties u_props (
		.clk           (clk),
		.reset         (reset),
		.i_instr       (i_instr),
		.i_instr_valid (i_instr_valid),
		.o_instr_ready (o_instr_ready),
		.o_out         (o_out),
		.o_out_valid   (o_out_valid),
		.i_out_ready   (i_out_ready)
	);

	always #10 clk = ~clk; // 20 ns period

	// watchdog counting every cycle
	always @(posedge clk)
	begin
		cycles++;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout after %0d cycles, only %0d of %0d expected results arrived",
				cycles, received, exp_q.size());
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0d ns %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ======================================================================
	// test data
	// ======================================================================
	task automatic load_testdata;
		logic [23:0] rec;
		int          per_test;
		per_test  = 0;
		n_records = 0;
		for (int a = 0; a < $size(tdata); a++)
			tdata[a] = {4'hF, 20'(a)};  // kind F marks the end of the file
		$readmemh("tb/pat_testdata.txt", tdata);
		while (n_records < $size(tdata) && tdata[n_records][23:20] != 4'hF)
		begin
			rec = tdata[n_records];
			n_records++;
			case (rec[23:20])
				4'h0: instr_q.push_back(rec[19:0]);
				4'h1:
				begin
					exp_q.push_back(rec);
					per_test++;
				end
				4'h2:
				begin
					exp_count.push_back(per_test); // close the test
					per_test = 0;
				end
				default:
				begin
					errors++;
					$display("test data entry %0d has an unknown kind, %h", n_records, rec);
				end
			endcase
		end
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("no expected results were loaded from the test data file");
		end
	endtask

	// ======================================================================
	// driver and monitor
	// ======================================================================
	task automatic drive_instrs;
		logic accepted;
		foreach (instr_q[i])
		begin
			gap_rng = xorshift32(gap_rng);
			while (gap_rng[1:0] == 2'b00)     // about one cycle in four idle
			begin
				i_instr_valid = 1'b0;
				@(posedge clk);
				#1;
				gap_rng = xorshift32(gap_rng);
			end
			i_instr       = instr_t'(instr_q[i]);
			i_instr_valid = 1'b1;
			accepted      = 1'b0;
			while (!accepted)
			begin
				@(negedge clk);
				accepted = o_instr_ready;     // transfer at the coming edge
				@(posedge clk);
				#1;
			end
		end
		i_instr_valid = 1'b0;
		i_instr       = INSTR_NOP;
	endtask

	// waits for one accepted result while sink ready changes just after each edge
	task automatic wait_result(input logic random_ready, output result_t res);
		logic taken;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = o_out_valid && i_out_ready;
			res   = o_out;
			@(posedge clk);
			#1;
			ready_rng   = xorshift32(ready_rng);
			i_out_ready = random_ready ? (ready_rng[2:0] > 3'd2) : 1'b1;
		end
	endtask

	task automatic collect_results;
		result_t     got;
		result_t     want;
		logic [23:0] rec;
		int          idx;
		int          errs_before;
		idx = 0;
		foreach (exp_count[t])
		begin
			errs_before = errors;
			for (int k = 0; k < exp_count[t]; k++)
			begin
				// last test runs with back-pressure
				wait_result(t == exp_count.size() - 1, got);
				received++;
				rec  = exp_q[idx];
				want = {rec[15:8], rec[4], rec[0]}; // acc, z, n
				idx++;
				check_value($sformatf("test %0d result %0d", t + 1, k + 1),
					{22'b0, got}, {22'b0, want});
			end
			$display("test %0d done, %0d results, %0d errors", t + 1, exp_count[t],
				errors - errs_before);
		end
		i_out_ready = 1'b1;
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial
	begin
		clk           = 1'b0;
		reset         = 1'b1;
		i_instr       = INSTR_NOP;
		i_instr_valid = 1'b0;
		i_out_ready   = 1'b1;
		errors        = 0;
		checks        = 0;
		received      = 0;
		extras        = 0;
		cycles        = 0;
		limit         = 0;
		gap_rng       = 32'h9548_ad69;
		ready_rng     = xorshift32(gap_rng);
		load_testdata();
		limit = 10 * n_records + 200;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		// input side must take words in the first cycle out of reset
		check_value("instruction ready after reset", 32'(o_instr_ready), 32'd1);
		fork
			drive_instrs();
			collect_results();
		join
		// a late result here would be a duplicate
		repeat (20)
		begin
			@(negedge clk);
			if (o_out_valid)
				extras++;
		end
		check_value("results after the last expected one", 32'(extras), 32'd0);
		$display("%0d tests, %0d checks, %0d errors", exp_count.size(), checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/pat_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// handshake rules on the two external streams of pat_core
module pat_core_properties
	import pat_pkg::*;
(
	input wire logic    clk,
	input wire logic    reset,
	input wire instr_t  i_instr,
	input wire logic    i_instr_valid,
	input wire logic    o_instr_ready,
	input wire result_t o_out,
	input wire logic    o_out_valid,
	input wire logic    i_out_ready
);

	// source holds its word until taken
	a_instr_hold: assert property (@(posedge clk) disable iff (reset)
		i_instr_valid && !o_instr_ready |=> i_instr_valid && $stable(i_instr))
		else $error("instruction word dropped or changed while not ready");

	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out))
		else $error("result dropped or changed while not ready");

	// covers the reset cycles and the first one after
	a_out_reset: assert property (@(posedge clk) reset |=> !o_out_valid)
		else $error("result valid during or right after reset");

	a_no_x: assert property (@(posedge clk)
		!reset |-> !$isunknown({i_instr_valid, o_instr_ready, o_out_valid, i_out_ready}))
		else $error("handshake signal unknown after reset");

endmodule

`default_nettype wire

// ==== src/pat_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_core
	import pat_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  instr_t    i_instr,
	input  wire logic i_instr_valid,
	output logic      o_instr_ready,
	output result_t   o_out,
	output logic      o_out_valid,
	input  wire logic i_out_ready
);

	// ======================================================================
	// internal streams
	// ======================================================================
	instr_t  skid_instr;   // in_skid -> decode
	logic    skid_valid;
	logic    dec_ready;
	ctrl_t   dec_ctrl;     // decode -> execute
	logic    dec_valid;
	logic    ex_ready;
	result_t ex_result;    // execute -> out_skid
	logic    ex_valid;
	logic    oskid_ready;

	stream_skid #(.payload_t(instr_t)) in_skid (
		.clk     (clk),
		.reset   (reset),
		.i_data  (i_instr),
		.i_valid (i_instr_valid),
		.o_ready (o_instr_ready),
		.o_data  (skid_instr),
		.o_valid (skid_valid),
		.i_ready (dec_ready)
	);

	instr_decode u_decode (
		.clk     (clk),
		.reset   (reset),
		.i_instr (skid_instr),
		.i_valid (skid_valid),
		.o_ready (dec_ready),
		.o_ctrl  (dec_ctrl),
		.o_valid (dec_valid),
		.i_ready (ex_ready)
	);

	exec_stage u_exec (
		.clk      (clk),
		.reset    (reset),
		.i_ctrl   (dec_ctrl),
		.i_valid  (dec_valid),
		.o_ready  (ex_ready),
		.o_result (ex_result),
		.o_valid  (ex_valid),
		.i_ready  (oskid_ready)
	);

	stream_skid #(.payload_t(result_t)) out_skid (
		.clk     (clk),
		.reset   (reset),
		.i_data  (ex_result),
		.i_valid (ex_valid),
		.o_ready (oskid_ready),
		.o_data  (o_out),
		.o_valid (o_out_valid),
		.i_ready (i_out_ready)
	);

endmodule

`default_nettype wire

// ==== src/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage
	import pat_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  ctrl_t     i_ctrl,
	input  wire logic i_valid,
	output logic      o_ready,
	output result_t   o_result,
	output logic      o_valid,
	input  wire logic i_ready
);

	// ======================================================================
	// architectural state
	// ======================================================================
	logic [DATA_W-1:0]  acc;
	logic               z;
	logic               n;
	logic [DATA_W-1:0]  dmem [DMEM_DEPTH];

	logic [DMEM_AW-1:0] mem_addr;
	logic [DATA_W-1:0]  mem_rd;
	logic [DATA_W-1:0]  alu_b;
	logic [DATA_W-1:0]  alu_y;
	logic               stall;   // out word waiting for room downstream
	logic               commit;

	// reads and writes share this stage, so a read always sees older writes
	assign mem_addr = i_ctrl.operand[DMEM_AW-1:0];
	assign mem_rd   = dmem[mem_addr];
	assign alu_b    = i_ctrl.use_mem ? mem_rd : i_ctrl.operand;

	pat_alu u_alu (
		.i_a     (acc),
		.i_b     (alu_b),
		.i_op    (i_ctrl.alu_op),
		.i_shift (i_ctrl.shift),
		.o_y     (alu_y)
	);

	// ======================================================================
	// handshake
	// ======================================================================
	assign stall   = i_valid && i_ctrl.emit_out && !i_ready;
	assign commit  = i_valid && !stall;
	assign o_ready = !stall;
	assign o_valid = i_valid && i_ctrl.emit_out; // independent of i_ready

	// result is the state before this word, acc and flags are stable while stalled
	assign o_result.acc = acc;
	assign o_result.z   = z;
	assign o_result.n   = n;

	// ======================================================================
	// commit
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			z   <= 1'b0;
			n   <= 1'b0;
			for (int i = 0; i < DMEM_DEPTH; i++)
				dmem[i] <= '0;      // memory starts cleared
		end
		else if (commit)
		begin
			if (i_ctrl.wr_acc)
				acc <= alu_y;
			if (i_ctrl.wr_mem)
				dmem[mem_addr] <= acc; // stm never writes acc in the same word
			// flags only move on test
			if (i_ctrl.set_flags)
			begin
				z <= (acc == '0);
				n <= acc[DATA_W-1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/pat_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_alu
	import pat_pkg::*;
(
	input  wire logic [DATA_W-1:0] i_a,     // accumulator
	input  wire logic [DATA_W-1:0] i_b,     // immediate or memory word
	input  alu_op_e                i_op,
	input  shift_e                 i_shift,
	output logic [DATA_W-1:0]      o_y
);

	logic [SHAMT_W-1:0] shamt;
	logic [DATA_W-1:0]  fill_mask;  // ones in the vacated low bits
	logic [DATA_W-1:0]  shift_y;

	assign shamt     = i_b[SHAMT_W-1:0];
	assign fill_mask = ~({DATA_W{1'b1}} << shamt);

	// ======================================================================
	// shifter
	// ======================================================================
	always_comb
	begin
		case (i_shift)
			SH_SHL:  shift_y = i_a << shamt;
			SH_SHLO: shift_y = (i_a << shamt) | fill_mask;
			SH_SHR:  shift_y = i_a >> shamt;
			SH_ASR:  shift_y = DATA_W'($signed(i_a) >>> shamt); // sign copied in
			default: shift_y = i_a;
		endcase
	end

	// ======================================================================
	// result select
	// ======================================================================
	always_comb
	begin
		case (i_op)
			ALU_PASS_B: o_y = i_b;           // ldi, ldm
			ALU_OR:     o_y = i_a | i_b;
			ALU_AND:    o_y = i_a & i_b;
			ALU_ADD:    o_y = i_a + i_b;     // wraps mod 256
			ALU_SUB:    o_y = i_a - i_b;
			ALU_NOT:    o_y = ~i_a;
			ALU_SHIFT:  o_y = shift_y;
			default:    o_y = i_b;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode
	import pat_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  instr_t    i_instr,
	input  wire logic i_valid,
	output logic      o_ready,
	output ctrl_t     o_ctrl,
	output logic      o_valid,
	input  wire logic i_ready
);

	// ======================================================================
	// tier resolution
	// ======================================================================
	logic               is_i8;
	logic               is_i3;
	logic [3:0]         op3;       // i3 opcode
	logic [3:0]         op0;       // i0 opcode
	logic [SHAMT_W-1:0] imm3;
	ctrl_t              ctrl_next;
	ctrl_t              ctrl_r;
	logic               valid_r;

	assign op3   = i_instr.imm[7:4];
	assign op0   = i_instr.imm[3:0];
	assign imm3  = i_instr.imm[SHAMT_W-1:0];
	assign is_i8 = (i_instr.opcode != OP_PREFIX);
	assign is_i3 = !is_i8 && (op3 != OP_PREFIX);
	// anything left is i0

	// ======================================================================
	// opcode to control word
	// ======================================================================
	always_comb
	begin
		// default is a word that writes nothing
		ctrl_next           = '0;
		ctrl_next.alu_op    = ALU_PASS_B;
		ctrl_next.shift     = SH_SHL;
		ctrl_next.operand   = i_instr.imm;

		if (i_instr.field_op)
		begin
			ctrl_next.operand = '0;       // field ops are not supported here
		end
		else if (is_i8)
		begin
			case (i_instr.opcode)
				OP_OR:   begin ctrl_next.alu_op = ALU_OR;  ctrl_next.wr_acc = 1'b1; end
				OP_AND:  begin ctrl_next.alu_op = ALU_AND; ctrl_next.wr_acc = 1'b1; end
				OP_ADD:  begin ctrl_next.alu_op = ALU_ADD; ctrl_next.wr_acc = 1'b1; end
				OP_SUB:  begin ctrl_next.alu_op = ALU_SUB; ctrl_next.wr_acc = 1'b1; end
				OP_LDI:  ctrl_next.wr_acc = 1'b1;                  // pass b
				OP_LDM:  begin ctrl_next.use_mem = 1'b1; ctrl_next.wr_acc = 1'b1; end
				OP_ORM:  begin ctrl_next.alu_op = ALU_OR;  ctrl_next.use_mem = 1'b1;
				               ctrl_next.wr_acc = 1'b1; end
				OP_ANDM: begin ctrl_next.alu_op = ALU_AND; ctrl_next.use_mem = 1'b1;
				               ctrl_next.wr_acc = 1'b1; end
				OP_ADDM: begin ctrl_next.alu_op = ALU_ADD; ctrl_next.use_mem = 1'b1;
				               ctrl_next.wr_acc = 1'b1; end
				OP_SUBM: begin ctrl_next.alu_op = ALU_SUB; ctrl_next.use_mem = 1'b1;
				               ctrl_next.wr_acc = 1'b1; end
				OP_STM:  ctrl_next.wr_mem = 1'b1;                  // acc to dmem[imm]
				default: ;                                         // branches, setsp etc
			endcase
		end
		else if (is_i3)
		begin
			ctrl_next.operand = {{(DATA_W-SHAMT_W){1'b0}}, imm3}; // zero extend
			ctrl_next.alu_op  = ALU_SHIFT;
			case (op3)
				OP3_SHL:  begin ctrl_next.shift = SH_SHL;  ctrl_next.wr_acc = 1'b1; end
				OP3_SHLO: begin ctrl_next.shift = SH_SHLO; ctrl_next.wr_acc = 1'b1; end
				OP3_SHR:  begin ctrl_next.shift = SH_SHR;  ctrl_next.wr_acc = 1'b1; end
				OP3_ASR:  begin ctrl_next.shift = SH_ASR;  ctrl_next.wr_acc = 1'b1; end
				OP3_OUT:  ctrl_next.emit_out = 1'b1;
				default:  ;
			endcase
		end
		else
		begin
			case (op0)
				OP0_NOT:  begin ctrl_next.alu_op = ALU_NOT; ctrl_next.wr_acc = 1'b1; end
				OP0_TEST: ctrl_next.set_flags = 1'b1;
				OP0_NOP:  ctrl_next.operand = '0;
				default:  ;                                         // mov, return, sp ops
			endcase
		end
	end

	// ======================================================================
	// pipeline register
	// ======================================================================
	assign o_ready = !valid_r || i_ready; // empty or draining this cycle
	assign o_valid = valid_r;
	assign o_ctrl  = ctrl_r;

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_r <= 1'b0;
		else if (o_ready)
			valid_r <= i_valid;
	end

	always_ff @(posedge clk)
	begin
		if (o_ready && i_valid)
			ctrl_r <= ctrl_next;
	end

endmodule

`default_nettype wire

// ==== src/stream_skid.sv ====
`timescale 1ns/1ps
`default_nettype none

// two deep valid/ready buffer, both sides registered, order kept
module stream_skid #(
	parameter type payload_t = logic
) (
	input  wire logic clk,
	input  wire logic reset,
	input  payload_t  i_data,
	input  wire logic i_valid,
	output logic      o_ready,
	output payload_t  o_data,
	output logic      o_valid,
	input  wire logic i_ready
);

	payload_t head_data; // entry that is offered downstream
	payload_t tail_data; // second entry, only while head is stuck
	logic     head_valid;
	logic     tail_valid;
	logic     push;
	logic     pop;

	assign push = i_valid && o_ready;
	assign pop  = head_valid && i_ready;

	// tail only ever holds data when head does, so tail alone means full
	assign o_ready = !tail_valid;
	assign o_valid = head_valid;
	assign o_data  = head_data;

	// control state
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			head_valid <= 1'b0;
			tail_valid <= 1'b0;
		end
		else if (pop)
		begin
			if (tail_valid)
				tail_valid <= 1'b0;    // tail moves up, push is blocked here
			else
				head_valid <= push;    // refill straight from input
		end
		else if (push)
		begin
			if (head_valid)
				tail_valid <= 1'b1;
			else
				head_valid <= 1'b1;
		end
	end

	// payload path
	always_ff @(posedge clk)
	begin
		if (pop && tail_valid)
			head_data <= tail_data;
		else if (push && (pop || !head_valid))
			head_data <= i_data;
		else if (push)
			tail_data <= i_data;   // head busy and not leaving
	end

endmodule

`default_nettype wire

// ==== src/pat_pkg.sv ====
`default_nettype none

package pat_pkg;

	// ======================================================================
	// widths
	// ======================================================================
	localparam int DATA_W     = 8;  // acc, data and immediate
	localparam int INSTR_W    = 20; // full instruction word
	localparam int DMEM_DEPTH = 8;  // data memory words
	localparam int DMEM_AW    = 3;  // data memory address bits
	localparam int SHAMT_W    = 3;  // shift amount / i3 immediate

	// ======================================================================
	// opcode space
	// ======================================================================
	// i8 tier
	localparam logic [3:0] OP_OR     = 4'b0000;
	localparam logic [3:0] OP_AND    = 4'b0001;
	localparam logic [3:0] OP_ADDM   = 4'b0010;
	localparam logic [3:0] OP_SUBM   = 4'b0011;
	localparam logic [3:0] OP_ADD    = 4'b0100;
	localparam logic [3:0] OP_SUB    = 4'b0101;
	localparam logic [3:0] OP_LDI    = 4'b0110;
	localparam logic [3:0] OP_LDM    = 4'b0111;
	localparam logic [3:0] OP_STM    = 4'b1011;
	localparam logic [3:0] OP_ORM    = 4'b1101;
	localparam logic [3:0] OP_ANDM   = 4'b1110;
	localparam logic [3:0] OP_PREFIX = 4'b1111; // escape into the next tier

	// i3 tier, opcode sits in imm[7:4]
	localparam logic [3:0] OP3_SHL  = 4'b0000;
	localparam logic [3:0] OP3_SHLO = 4'b0001;
	localparam logic [3:0] OP3_SHR  = 4'b0010;
	localparam logic [3:0] OP3_ASR  = 4'b0011;
	localparam logic [3:0] OP3_OUT  = 4'b1000;

	// i0 tier, opcode sits in imm[3:0]
	localparam logic [3:0] OP0_NOT  = 4'b0000;
	localparam logic [3:0] OP0_TEST = 4'b0010;
	localparam logic [3:0] OP0_NOP  = 4'b1111;

	localparam logic [INSTR_W-1:0] INSTR_NOP = 20'h06FF5;

	// ======================================================================
	// types
	// ======================================================================
	typedef struct packed {
		logic [4:0]        fieldp;   // not used by this core
		logic [1:0]        cond;     // not used, no branches
		logic              field_op; // field ops run as nop
		logic [3:0]        opcode;
		logic [DATA_W-1:0] imm;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT,
		ALU_SHIFT
	} alu_op_e;

	typedef enum logic [1:0] {
		SH_SHL,
		SH_SHLO,
		SH_SHR,
		SH_ASR
	} shift_e;

	// one decoded instruction as seen by execute
	typedef struct packed {
		alu_op_e           alu_op;
		shift_e            shift;
		logic              use_mem;   // b operand from dmem
		logic              wr_acc;
		logic              wr_mem;
		logic              set_flags;
		logic              emit_out;
		logic [DATA_W-1:0] operand;   // immediate, low bits double as address
	} ctrl_t;

	typedef struct packed {
		logic [DATA_W-1:0] acc;
		logic              z;
		logic              n;
	} result_t;

endpackage

`default_nettype wire
